// ==== logic/uart_pkg.sv ====
package uart_pkg;

  // Bit timing
  localparam int BIT_CNT_W = 16; // Wide enough for any divisor in use
  localparam int DATA_BITS = 8;

  // Serial line idles high, stop bit is the idle level
  localparam logic LINE_IDLE = 1'b1;

  typedef logic [DATA_BITS-1:0] byte_t;
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

endpackage

// ==== logic/bridge_pkg.sv ====
package bridge_pkg;

  localparam int MAX_FRAME_BYTES = 8;

  typedef logic [MAX_FRAME_BYTES*8-1:0] frame_t; // Byte 0 in the low bits
  typedef logic [3:0] len_t;                     // 0 to MAX_FRAME_BYTES

  // Frame terminators
  localparam logic [7:0] HOST_TERM_HI = 8'hBE;
  localparam logic [7:0] HOST_TERM_LO = 8'hEF;
  localparam logic [7:0] BLE_TERM     = 8'h0D; // Carriage return

  // "AT+RX\r", first byte in the low bits
  localparam logic [47:0] POLL_CMD = 48'h0D_58_52_2B_54_41;
  localparam int          POLL_LEN = 6;

  // Reply status byte
  localparam logic [7:0] RSP_OK       = 8'h00;
  localparam logic [7:0] RSP_OVERFLOW = 8'hFE;
  localparam logic [7:0] RSP_TIMEOUT  = 8'hFF;

  typedef enum logic [3:0] {
    IDLE,
    FWD_SEND,
    FWD_TERM,
    POLL_SEND,
    WAIT_RSP,
    RPL_STATUS,
    RPL_DATA,
    RPL_TERM_HI,
    RPL_TERM_LO,
    CLEAR
  } seq_state_t;

endpackage

// ==== logic/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 5208
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  i_rx,
  output byte_t o_data,
  output logic  o_valid
);

  localparam bit_cnt_t HALF_BIT = bit_cnt_t'(CLKS_PER_BIT / 2 - 1);
  localparam bit_cnt_t FULL_BIT = bit_cnt_t'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t  state_q;
  logic [1:0] sync_q;
  bit_cnt_t   cnt_q;
  logic [2:0] bit_idx_q;
  byte_t      shift_q;
  logic       rx_s;

  assign rx_s = sync_q[1];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync_q    <= {2{LINE_IDLE}};
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      o_valid   <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], i_rx};
      o_valid <= 1'b0;
      cnt_q   <= cnt_q + bit_cnt_t'(1);
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (rx_s != LINE_IDLE) state_q <= RX_START; // Falling start edge
        end
        RX_START: begin
          if (cnt_q == HALF_BIT) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            // Line back high at mid start bit means a glitch
            state_q   <= (rx_s != LINE_IDLE) ? RX_DATA : RX_IDLE;
          end
        end
        RX_DATA: begin
          if (cnt_q == FULL_BIT) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'(DATA_BITS - 1)) state_q <= RX_STOP;
          end
        end
        default: begin
          if (cnt_q == FULL_BIT) begin
            o_valid <= (rx_s == LINE_IDLE); // Bad stop bit gives no strobe
            state_q <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && cnt_q == FULL_BIT) shift_q <= {rx_s, shift_q[DATA_BITS-1:1]};
    if (state_q == RX_STOP && cnt_q == FULL_BIT) o_data <= shift_q;
  end

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 5208
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  i_start,
  input  byte_t i_data,
  output logic  o_tx,
  output logic  o_busy
);

  localparam bit_cnt_t FULL_BIT = bit_cnt_t'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t  state_q;
  bit_cnt_t   cnt_q;
  logic [2:0] bit_idx_q;
  byte_t      shift_q;
  logic       tx_q;
  logic       bit_end;

  assign bit_end = (cnt_q == FULL_BIT);
  assign o_busy  = (state_q != TX_IDLE); // Start, 8 data and stop bits
  assign o_tx    = tx_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q   <= TX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      tx_q      <= LINE_IDLE;
    end else if (state_q == TX_IDLE) begin
      cnt_q     <= '0;
      bit_idx_q <= '0;
      if (i_start) begin
        state_q <= TX_START;
        tx_q    <= ~LINE_IDLE;
      end
    end else if (bit_end) begin
      cnt_q <= '0;
      case (state_q)
        TX_START: begin
          state_q <= TX_DATA;
          tx_q    <= shift_q[0];
        end
        TX_DATA: begin
          bit_idx_q <= bit_idx_q + 3'd1;
          if (bit_idx_q == 3'(DATA_BITS - 1)) begin
            state_q <= TX_STOP;
            tx_q    <= LINE_IDLE;
          end else begin
            tx_q <= shift_q[0];
          end
        end
        default: state_q <= TX_IDLE; // End of stop bit
      endcase
    end else begin
      cnt_q <= cnt_q + bit_cnt_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == TX_IDLE && i_start) shift_q <= i_data;
    else if (bit_end && state_q != TX_STOP) shift_q <= shift_q >> 1; // LSB first
  end

  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (reset) i_start |-> !o_busy
  );

endmodule

// ==== logic/frame_accumulator.sv ====
`timescale 1ns/100ps

module frame_accumulator import uart_pkg::*; import bridge_pkg::*; #(
  parameter bit TWO_BYTE_TERM = 1'b0
) (
  input  logic   clk,
  input  logic   reset,
  input  byte_t  i_data,
  input  logic   i_valid,
  input  logic   i_clear,
  output frame_t o_data,
  output len_t   o_len,
  output logic   o_done,
  output logic   o_overflow
);

  frame_t     data_d;
  len_t       len_d;
  logic       ovf_d;
  logic       pend_q, pend_d; // 0xBE held back in two-byte mode
  logic       fin_q;          // Frame finished, next byte starts a new one
  logic       done_d;
  logic [1:0] st_en;
  byte_t      st_byte [2];

  always_comb begin
    st_en      = '0;
    st_byte[0] = HOST_TERM_HI;
    st_byte[1] = i_data;
    pend_d     = pend_q;
    done_d     = 1'b0;
    if (TWO_BYTE_TERM) begin
      if (pend_q && i_data == HOST_TERM_LO) begin
        pend_d = 1'b0;
        done_d = 1'b1;
      end else begin
        st_en[0] = pend_q;                  // Held 0xBE was payload after all
        pend_d   = (i_data == HOST_TERM_HI);
        st_en[1] = !pend_d;
      end
    end else begin
      done_d   = (i_data == BLE_TERM);
      st_en[1] = !done_d;
    end

    data_d = o_data;
    len_d  = fin_q ? len_t'(0) : o_len;
    ovf_d  = o_overflow && !fin_q;
    for (int k = 0; k < 2; k++) begin
      if (st_en[k]) begin
        if (len_d == len_t'(MAX_FRAME_BYTES)) begin
          ovf_d = 1'b1; // Byte dropped, length stays at max
        end else begin
          data_d[len_d*8 +: 8] = st_byte[k];
          len_d                = len_d + len_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      o_len      <= '0;
      o_overflow <= 1'b0;
      o_done     <= 1'b0;
      pend_q     <= 1'b0;
      fin_q      <= 1'b0;
    end else if (i_clear) begin
      o_len      <= '0;
      o_overflow <= 1'b0;
      o_done     <= 1'b0;
      pend_q     <= 1'b0;
      fin_q      <= 1'b0;
    end else begin
      o_done <= i_valid && done_d;
      if (i_valid) begin
        o_len      <= len_d;
        o_overflow <= ovf_d;
        pend_q     <= pend_d;
        fin_q      <= done_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid && !i_clear) o_data <= data_d;
  end

  a_len_in_range: assert property (
    @(posedge clk) disable iff (reset) o_len <= len_t'(MAX_FRAME_BYTES)
  );

endmodule

// ==== logic/bridge_sequencer.sv ====
`timescale 1ns/100ps

module bridge_sequencer import uart_pkg::*; import bridge_pkg::*; #(
  parameter int TIMEOUT_CYCLES = 4000000
) (
  input  logic   clk,
  input  logic   reset,
  input  frame_t i_host_data,
  input  len_t   i_host_len,
  input  logic   i_host_done,
  input  logic   i_host_overflow,
  output logic   o_host_clear,
  input  frame_t i_ble_data,
  input  len_t   i_ble_len,
  input  logic   i_ble_done,
  input  logic   i_ble_overflow,
  output logic   o_ble_clear,
  output logic   o_ble_start,
  output byte_t  o_ble_byte,
  input  logic   i_ble_busy,
  output logic   o_host_start,
  output byte_t  o_host_byte,
  input  logic   i_host_busy
);

  localparam int TIMER_W = $clog2(TIMEOUT_CYCLES);

  seq_state_t         state_q, state_d;
  len_t               idx_q;
  logic [TIMER_W-1:0] timer_q;
  logic               timeout;
  frame_t             host_frame_q, rsp_data_q;
  len_t               host_len_q, rsp_len_q;
  byte_t              status_q;
  logic               ble_clr_q;
  logic               ble_ready, host_ready;
  logic               ble_fire, host_fire;
  byte_t              ble_byte_d, host_byte_d;

  // A start pulse is in flight until busy rises
  assign ble_ready  = !i_ble_busy && !o_ble_start;
  assign host_ready = !i_host_busy && !o_host_start;
  assign timeout    = (timer_q == TIMER_W'(TIMEOUT_CYCLES - 1));

  assign o_host_clear = (state_q == CLEAR);
  assign o_ble_clear  = (state_q == CLEAR) || ble_clr_q;

  always_comb begin
    state_d     = state_q;
    ble_fire    = 1'b0;
    host_fire   = 1'b0;
    ble_byte_d  = BLE_TERM;
    host_byte_d = status_q;
    case (state_q)
      CLEAR: state_d = IDLE;
      IDLE: begin
        if (i_host_done) state_d = i_host_overflow ? CLEAR : FWD_SEND;
      end
      FWD_SEND: begin
        if (idx_q == host_len_q) begin
          state_d = FWD_TERM;
        end else begin
          ble_fire   = ble_ready;
          ble_byte_d = host_frame_q[idx_q*8 +: 8];
        end
      end
      FWD_TERM: begin
        ble_fire = ble_ready;
        if (ble_ready) state_d = POLL_SEND;
      end
      POLL_SEND: begin
        if (idx_q == len_t'(POLL_LEN)) begin
          state_d = WAIT_RSP;
        end else begin
          ble_fire   = ble_ready;
          ble_byte_d = POLL_CMD[idx_q*8 +: 8];
        end
      end
      WAIT_RSP: begin
        if (i_ble_done || timeout) state_d = RPL_STATUS;
      end
      RPL_STATUS: begin
        host_fire = host_ready;
        if (host_ready) state_d = RPL_DATA;
      end
      RPL_DATA: begin
        if (idx_q == rsp_len_q) begin
          state_d = RPL_TERM_HI;
        end else begin
          host_fire   = host_ready;
          host_byte_d = rsp_data_q[idx_q*8 +: 8];
        end
      end
      RPL_TERM_HI: begin
        host_fire   = host_ready;
        host_byte_d = HOST_TERM_HI;
        if (host_ready) state_d = RPL_TERM_LO;
      end
      RPL_TERM_LO: begin
        host_fire   = host_ready;
        host_byte_d = HOST_TERM_LO;
        if (host_ready) state_d = CLEAR;
      end
      default: state_d = CLEAR;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q      <= CLEAR; // Empties both accumulators first
      idx_q        <= '0;
      timer_q      <= '0;
      host_len_q   <= '0;
      rsp_len_q    <= '0;
      status_q     <= RSP_OK;
      ble_clr_q    <= 1'b0;
      o_ble_start  <= 1'b0;
      o_host_start <= 1'b0;
    end else begin
      state_q      <= state_d;
      o_ble_start  <= ble_fire;
      o_host_start <= host_fire;
      ble_clr_q    <= (state_q == IDLE) && i_host_done && !i_host_overflow;
      if (state_d != state_q) idx_q <= '0; // Each send state counts from zero
      else if (ble_fire || host_fire) idx_q <= idx_q + len_t'(1);
      timer_q <= (state_q == WAIT_RSP) ? timer_q + TIMER_W'(1) : '0;
      if (state_q == IDLE && i_host_done) host_len_q <= i_host_len;
      if (state_q == WAIT_RSP) begin
        if (i_ble_done) begin
          rsp_len_q <= i_ble_len;
          status_q  <= i_ble_overflow ? RSP_OVERFLOW : RSP_OK;
        end else if (timeout) begin
          rsp_len_q <= '0;
          status_q  <= RSP_TIMEOUT;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && i_host_done) host_frame_q <= i_host_data;
    if (state_q == WAIT_RSP && i_ble_done) rsp_data_q <= i_ble_data;
    if (ble_fire) o_ble_byte <= ble_byte_d;
    if (host_fire) o_host_byte <= host_byte_d;
  end

  a_ble_start_idle: assert property (
    @(posedge clk) disable iff (reset) o_ble_start |-> !i_ble_busy
  );
  a_host_start_idle: assert property (
    @(posedge clk) disable iff (reset) o_host_start |-> !i_host_busy
  );

endmodule

// ==== logic/ble_bridge_top.sv ====
`timescale 1ns/100ps

module ble_bridge_top import uart_pkg::*; import bridge_pkg::*; #(
  parameter int CLKS_PER_BIT   = 5208,   // 9600 baud at 50 MHz
  parameter int TIMEOUT_CYCLES = 4000000
) (
  input  logic clk,
  input  logic reset,
  input  logic i_host_rx,
  output logic o_host_tx,
  input  logic i_ble_rx,
  output logic o_ble_tx
);

  byte_t  host_rx_byte, ble_rx_byte;
  logic   host_rx_valid, ble_rx_valid;
  frame_t host_frame, ble_frame;
  len_t   host_len, ble_len;
  logic   host_done, ble_done;
  logic   host_ovf, ble_ovf;
  logic   host_clear, ble_clear;
  logic   host_start, ble_start;
  logic   host_busy, ble_busy;
  byte_t  host_byte, ble_byte;

  // Host side
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_host_rx (
    .clk(clk), .reset(reset), .i_rx(i_host_rx),
    .o_data(host_rx_byte), .o_valid(host_rx_valid)
  );

  frame_accumulator #(.TWO_BYTE_TERM(1'b1)) u_host_acc ( // Ends in 0xBE 0xEF
    .clk(clk), .reset(reset), .i_data(host_rx_byte), .i_valid(host_rx_valid),
    .i_clear(host_clear), .o_data(host_frame), .o_len(host_len),
    .o_done(host_done), .o_overflow(host_ovf)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_host_tx (
    .clk(clk), .reset(reset), .i_start(host_start), .i_data(host_byte),
    .o_tx(o_host_tx), .o_busy(host_busy)
  );

  // BLE module side
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_ble_rx (
    .clk(clk), .reset(reset), .i_rx(i_ble_rx),
    .o_data(ble_rx_byte), .o_valid(ble_rx_valid)
  );

  frame_accumulator #(.TWO_BYTE_TERM(1'b0)) u_ble_acc ( // Ends in carriage return
    .clk(clk), .reset(reset), .i_data(ble_rx_byte), .i_valid(ble_rx_valid),
    .i_clear(ble_clear), .o_data(ble_frame), .o_len(ble_len),
    .o_done(ble_done), .o_overflow(ble_ovf)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_ble_tx (
    .clk(clk), .reset(reset), .i_start(ble_start), .i_data(ble_byte),
    .o_tx(o_ble_tx), .o_busy(ble_busy)
  );

  bridge_sequencer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_seq (
    .clk(clk), .reset(reset),
    .i_host_data(host_frame), .i_host_len(host_len), .i_host_done(host_done),
    .i_host_overflow(host_ovf), .o_host_clear(host_clear),
    .i_ble_data(ble_frame), .i_ble_len(ble_len), .i_ble_done(ble_done),
    .i_ble_overflow(ble_ovf), .o_ble_clear(ble_clear),
    .o_ble_start(ble_start), .o_ble_byte(ble_byte), .i_ble_busy(ble_busy),
    .o_host_start(host_start), .o_host_byte(host_byte), .i_host_busy(host_busy)
  );

endmodule

// ==== sim/ble_bridge_tb.sv ====
`timescale 1ns/100ps

module ble_bridge_tb import uart_pkg::*;;

  localparam int CLKS_PER_BIT   = 8;
  localparam int TIMEOUT_CYCLES = 3000;

  logic clk;
  logic reset;
  logic host_rx, host_tx;
  logic ble_rx, ble_tx;

  logic [31:0] rng_state;
  int          error_count;
  int          test_count;
  int          failed_tests;

  byte_t payload_q[$];  // Host command payload
  byte_t rsp_q[$];      // BLE response payload
  byte_t ble_q[$];      // Decoded from o_ble_tx
  byte_t host_q[$];     // Decoded from o_host_tx
  byte_t exp_ble_q[$];
  byte_t exp_host_q[$];

  // "AT+RX" then carriage return
  byte_t poll_bytes[6] = '{8'h41, 8'h54, 8'h2B, 8'h52, 8'h58, 8'h0D};

  ble_bridge_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) i_ble_bridge_top (
    .clk(clk), .reset(reset),
    .i_host_rx(host_rx), .o_host_tx(host_tx),
    .i_ble_rx(ble_rx), .o_ble_tx(ble_tx)
  );

  always #2 clk = ~clk;

  function automatic int unsigned rand_below(input int unsigned n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return (rng_state >> 16) % n;
  endfunction

  // Never 0xBE, 0x0D or 0xFF so no frame ends early
  function automatic byte_t rand_payload_byte();
    byte_t b;
    b = byte_t'(rand_below(256));
    while (b == 8'hBE || b == 8'h0D || b == 8'hFF) b = byte_t'(rand_below(256));
    return b;
  endfunction

  function automatic logic line_level(input bit host);
    return host ? host_tx : ble_tx;
  endfunction

  task automatic send_serial(input bit host, input byte_t b);
    logic [9:0] bits;
    bits = {LINE_IDLE, b, ~LINE_IDLE}; // Stop, data LSB first, start
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      if (host) host_rx <= bits[i];
      else ble_rx <= bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // Entered half a cycle after the start edge and samples each bit at mid-bit
  task automatic read_line_byte(input bit host, output byte_t b, output bit stop_ok);
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      b[i] = line_level(host);
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    stop_ok = (line_level(host) === LINE_IDLE);
  endtask

  initial begin : host_monitor
    byte_t b;
    bit    ok;
    forever begin
      @(negedge clk);
      if (!reset && host_tx === 1'b0) begin
        read_line_byte(1'b1, b, ok);
        if (ok) host_q.push_back(b);
        else begin
          $display("Stop bit missing on o_host_tx");
          error_count++;
        end
      end
    end
  end

  initial begin : ble_monitor
    byte_t b;
    bit    ok;
    forever begin
      @(negedge clk);
      if (!reset && ble_tx === 1'b0) begin
        read_line_byte(1'b0, b, ok);
        if (ok) ble_q.push_back(b);
        else begin
          $display("Stop bit missing on o_ble_tx");
          error_count++;
        end
      end
    end
  end

  task automatic make_payload(input int n);
    payload_q.delete();
    for (int k = 0; k < n; k++) payload_q.push_back(rand_payload_byte());
  endtask

  task automatic make_response(input int n);
    rsp_q.delete();
    for (int k = 0; k < n; k++) rsp_q.push_back(rand_payload_byte());
  endtask

  task automatic send_host_frame();
    foreach (payload_q[k]) send_serial(1'b1, payload_q[k]);
    send_serial(1'b1, 8'hBE);
    send_serial(1'b1, 8'hEF);
  endtask

  // BLE module model that answers the poll with the response and a carriage return
  task automatic answer_poll();
    foreach (rsp_q[k]) send_serial(1'b0, rsp_q[k]);
    send_serial(1'b0, 8'h0D);
  endtask

  task automatic wait_for_bytes(input bit host, input int count, input int limit,
                                output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < limit) begin
      @(negedge clk);
      n++;
      ok = host ? (host_q.size() >= count) : (ble_q.size() >= count);
    end
  endtask

  task automatic compare_queue(input string name, input bit host);
    string line;
    byte_t expv, act;
    int    n_exp, n_act;
    line  = host ? "o_host_tx" : "o_ble_tx";
    n_exp = host ? exp_host_q.size() : exp_ble_q.size();
    n_act = host ? host_q.size() : ble_q.size();
    if (n_act != n_exp) begin
      $display("Error %s: %s byte count expected %0d actual %0d", name, line, n_exp, n_act);
      error_count++;
    end else begin
      for (int k = 0; k < n_exp; k++) begin
        expv = host ? exp_host_q[k] : exp_ble_q[k];
        act  = host ? host_q[k] : ble_q[k];
        if (act !== expv) begin
          $display("Error %s: %s byte %0d expected 0x%02h actual 0x%02h",
                   name, line, k, expv, act);
          error_count++;
        end
      end
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("Test %s passed", name);
    end else begin
      failed_tests++;
      $display("Test %s failed", name);
    end
  endtask

  task automatic run_transaction(input string name, input bit silent);
    int errs_before;
    int n_rsp;
    bit ok;
    errs_before = error_count;
    ble_q.delete();
    host_q.delete();
    exp_ble_q.delete();
    exp_host_q.delete();
    // Expected BLE line is the payload, a carriage return and the poll
    foreach (payload_q[k]) exp_ble_q.push_back(payload_q[k]);
    exp_ble_q.push_back(8'h0D);
    foreach (poll_bytes[k]) exp_ble_q.push_back(poll_bytes[k]);
    // Expected reply is the status, up to 8 response bytes and 0xBE 0xEF
    n_rsp = silent ? 0 : ((rsp_q.size() > 8) ? 8 : rsp_q.size());
    if (silent) exp_host_q.push_back(8'hFF);
    else if (rsp_q.size() > 8) exp_host_q.push_back(8'hFE);
    else exp_host_q.push_back(8'h00);
    for (int k = 0; k < n_rsp; k++) exp_host_q.push_back(rsp_q[k]);
    exp_host_q.push_back(8'hBE);
    exp_host_q.push_back(8'hEF);

    send_host_frame();
    wait_for_bytes(1'b0, exp_ble_q.size(), 3000, ok);
    if (!ok) begin
      $display("%s: forwarded frame and poll not seen on o_ble_tx within timeout", name);
      error_count++;
    end else begin
      compare_queue(name, 1'b0);
      if (!silent) answer_poll();
      wait_for_bytes(1'b1, exp_host_q.size(), TIMEOUT_CYCLES + 3000, ok);
      if (!ok) begin
        $display("%s: no reply within timeout", name);
        error_count++;
      end else begin
        compare_queue(name, 1'b1);
      end
    end
    finish_test(name, errs_before);
  endtask

  // A frame with 10 payload bytes must be dropped without any output
  task automatic run_host_overflow();
    int errs_before;
    int n;
    errs_before = error_count;
    ble_q.delete();
    host_q.delete();
    make_payload(10);
    send_host_frame();
    n = 0;
    // A stray reply would only show up after the response timeout
    while (n < TIMEOUT_CYCLES + 1000 && ble_q.size() == 0 && host_q.size() == 0) begin
      @(negedge clk);
      n++;
    end
    if (ble_q.size() + host_q.size() != 0) begin
      $display("Error host_overflow: output bytes expected 0 actual %0d",
               ble_q.size() + host_q.size());
      error_count++;
    end
    finish_test("host_overflow", errs_before);
  endtask

  initial begin
    byte_t b;
    int    choice;
    clk          = 1'b0;
    reset        = 1'b1;
    host_rx      = LINE_IDLE;
    ble_rx       = LINE_IDLE;
    rng_state    = 32'd74;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);

    make_payload(rand_below(9));
    make_response(rand_below(9));
    run_transaction("normal_reply", 1'b0);

    make_payload(rand_below(9));
    run_transaction("timeout", 1'b1);

    make_payload(rand_below(9));
    make_response(10);
    run_transaction("response_overflow", 1'b0);

    run_host_overflow();
    make_payload(rand_below(9));
    make_response(rand_below(9));
    run_transaction("after_host_overflow", 1'b0);

    // 0xBE inside the payload and not followed by 0xEF
    payload_q.delete();
    payload_q.push_back(rand_payload_byte());
    payload_q.push_back(8'hBE);
    b = rand_payload_byte();
    if (b == 8'hEF) b = 8'h5A;
    payload_q.push_back(b);
    payload_q.push_back(rand_payload_byte());
    make_response(rand_below(9));
    run_transaction("embedded_be", 1'b0);

    for (int t = 0; t < 6; t++) begin
      choice = rand_below(3); // 0 normal, 1 silent, 2 long response
      make_payload(rand_below(9));
      make_response((choice == 2) ? 10 : rand_below(9));
      run_transaction($sformatf("random_%0d", t), choice == 1);
    end

    $display("Tests run %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== ble_bridge_top.f ====
logic/uart_pkg.sv
logic/bridge_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/frame_accumulator.sv
logic/bridge_sequencer.sv
logic/ble_bridge_top.sv
sim/ble_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: ble_bridge

sources:
  - files:
      - logic/uart_pkg.sv
      - logic/bridge_pkg.sv
      - logic/uart_rx.sv
      - logic/uart_tx.sv
      - logic/frame_accumulator.sv
      - logic/bridge_sequencer.sv
      - logic/ble_bridge_top.sv
  - target: simulation
    files:
      - sim/ble_bridge_tb.sv
